//--- Makefile
SRCS := $(shell grep -v '^+' filelist.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_mac_tx_ctrl: filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_mac_tx_ctrl -Mdir obj_dir -f filelist.f

run: obj_dir/Vtb_mac_tx_ctrl
	./obj_dir/Vtb_mac_tx_ctrl > sim.log 2>&1; cat sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- common/mac_tx_bus_pkg.sv
`default_nettype none

package mac_tx_bus_pkg;

    typedef enum logic {
        CMD_WRITE = 1'b0,
        CMD_READ  = 1'b1
    } cmd_kind_e;

    // one entry of the command queue, kind sits in bit 0
    typedef struct packed {
        logic [mac_tx_reg_pkg::REG_DATA_W-1:0] wdata;
        logic [mac_tx_reg_pkg::REG_ADDR_W-1:0] addr;
        cmd_kind_e                              kind;
    } reg_cmd_t;

    typedef struct packed {
        logic [mac_tx_reg_pkg::REG_DATA_W-1:0] data;
        logic [mac_tx_reg_pkg::REG_ADDR_W-1:0] addr;
    } reg_resp_t;

    // single cycle pulses from the transmit path
    typedef struct packed {
        logic babt;
        logic gra;
        logic txf;
        logic eberr;
        logic lc;
        logic rl;
        logic un;
    } tx_event_t;

    typedef struct packed {
        logic                                   en;
        logic [mac_tx_reg_pkg::REG_ADDR_W-1:0] addr;
        logic [mac_tx_reg_pkg::REG_DATA_W-1:0] data;
    } reg_write_t;

endpackage

`default_nettype wire

//--- common/mac_tx_reg_pkg.sv
`default_nettype none

package mac_tx_reg_pkg;

    localparam int REG_ADDR_W = 12;
    localparam int REG_DATA_W = 32;

    // transmit side of the ENET register map
    typedef enum logic [REG_ADDR_W-1:0] {
        EIR  = 12'h004,
        TDAR = 12'h014,
        ECR  = 12'h024,
        TCR  = 12'h0C4,
        PALR = 12'h0E4,
        PAUR = 12'h0E8,
        OPD  = 12'h0EC,
        TFWR = 12'h144,
        TDSR = 12'h184,
        TSEM = 12'h1A0,
        TAEM = 12'h1A4,
        TAFL = 12'h1A8,
        TIPG = 12'h1AC
    } reg_addr_e;

    // interrupt cause positions in EIR
    localparam int EIR_BABT_BIT  = 29;
    localparam int EIR_GRA_BIT   = 28;
    localparam int EIR_TXF_BIT   = 27;
    localparam int EIR_EBERR_BIT = 22;
    localparam int EIR_LC_BIT    = 21;
    localparam int EIR_RL_BIT    = 20;
    localparam int EIR_UN_BIT    = 19;

    localparam int TCR_GTS_BIT       = 0;
    localparam int TCR_FDEN_BIT      = 2;
    localparam int TCR_TFC_PAUSE_BIT = 3;
    localparam int TCR_ADDINS_BIT    = 8;
    localparam int TCR_CRCFWD_BIT    = 9;

    localparam int ECR_ETHER_EN_BIT = 1;
    localparam int TDAR_BIT         = 24;
    localparam int TFWR_STRFWD_BIT  = 8;

    // everything the transmit path needs from the register file
    typedef struct packed {
        logic        ether_en;
        logic        gts;
        logic        fden;
        logic        tfc_pause;
        logic        addins;
        logic        crcfwd;
        logic [31:0] palr;
        logic [31:0] paur;
        logic [31:0] opd;
        logic [31:0] tdsr;
        logic        strfwd;
        logic [7:0]  tfwr;
        logic [7:0]  tsem;
        logic [7:0]  tafl;
        logic [7:0]  taem;
        logic [15:0] tipg;
    } tx_config_t;

endpackage

`default_nettype wire

//--- filelist.f
common/mac_tx_reg_pkg.sv
common/mac_tx_bus_pkg.sv
src/mac_cmd_decoder.sv
regs/mac_tx_regs.sv
src/mac_event_collector.sv
src/mac_resp_arbiter.sv
src/mac_tx_ctrl.sv
tests/tb_mac_tx_ctrl.sv

//--- regs/mac_tx_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mac_tx_regs (
    input  wire logic                                  tx_clk,
    input  wire logic                                  rst_n,
    input  wire mac_tx_bus_pkg::reg_write_t            reg_write,
    input  wire logic [mac_tx_reg_pkg::REG_ADDR_W-1:0] rd_addr,
    output logic [mac_tx_reg_pkg::REG_DATA_W-1:0]      rd_data,
    input  wire logic                                  txf_done,
    output mac_tx_reg_pkg::tx_config_t                 tx_cfg
);

    mac_tx_reg_pkg::tx_config_t cfg_q;
    logic                       tdar;
    logic                       tdar_set;

    assign tdar_set = reg_write.en && (reg_write.addr == mac_tx_reg_pkg::TDAR);

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q <= '0;
        end else if (reg_write.en) begin
            case (reg_write.addr)
                mac_tx_reg_pkg::ECR: begin
                    cfg_q.ether_en <= reg_write.data[mac_tx_reg_pkg::ECR_ETHER_EN_BIT];
                end
                mac_tx_reg_pkg::TCR: begin
                    cfg_q.gts       <= reg_write.data[mac_tx_reg_pkg::TCR_GTS_BIT];
                    cfg_q.fden      <= reg_write.data[mac_tx_reg_pkg::TCR_FDEN_BIT];
                    cfg_q.tfc_pause <= reg_write.data[mac_tx_reg_pkg::TCR_TFC_PAUSE_BIT];
                    cfg_q.addins    <= reg_write.data[mac_tx_reg_pkg::TCR_ADDINS_BIT];
                    cfg_q.crcfwd    <= reg_write.data[mac_tx_reg_pkg::TCR_CRCFWD_BIT];
                end
                mac_tx_reg_pkg::PALR: cfg_q.palr <= reg_write.data;
                mac_tx_reg_pkg::PAUR: cfg_q.paur <= reg_write.data;
                mac_tx_reg_pkg::OPD:  cfg_q.opd  <= reg_write.data;
                mac_tx_reg_pkg::TDSR: cfg_q.tdsr <= reg_write.data;
                mac_tx_reg_pkg::TFWR: begin
                    cfg_q.strfwd <= reg_write.data[mac_tx_reg_pkg::TFWR_STRFWD_BIT];
                    cfg_q.tfwr   <= reg_write.data[7:0];
                end
                mac_tx_reg_pkg::TSEM: cfg_q.tsem <= reg_write.data[7:0];
                mac_tx_reg_pkg::TAEM: cfg_q.taem <= reg_write.data[7:0];
                mac_tx_reg_pkg::TAFL: cfg_q.tafl <= reg_write.data[7:0];
                mac_tx_reg_pkg::TIPG: cfg_q.tipg <= reg_write.data[15:0];
                default: begin
                end
            endcase
        end
    end

    // descriptor active flag, dropped when the MAC is disabled
    // a new TDAR write wins over a frame completing in the same cycle
    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            tdar <= 1'b0;
        end else if (!cfg_q.ether_en) begin
            tdar <= 1'b0;
        end else if (tdar_set) begin
            tdar <= 1'b1;
        end else if (txf_done) begin
            tdar <= 1'b0;
        end
    end

    always_comb begin
        rd_data = '0;
        case (rd_addr)
            mac_tx_reg_pkg::TDAR: begin
                rd_data[mac_tx_reg_pkg::TDAR_BIT] = tdar;
            end
            mac_tx_reg_pkg::TCR: begin
                rd_data[mac_tx_reg_pkg::TCR_GTS_BIT]       = cfg_q.gts;
                rd_data[mac_tx_reg_pkg::TCR_FDEN_BIT]      = cfg_q.fden;
                rd_data[mac_tx_reg_pkg::TCR_TFC_PAUSE_BIT] = cfg_q.tfc_pause;
                rd_data[mac_tx_reg_pkg::TCR_ADDINS_BIT]    = cfg_q.addins;
                rd_data[mac_tx_reg_pkg::TCR_CRCFWD_BIT]    = cfg_q.crcfwd;
            end
            default: begin
            end
        endcase
    end

    assign tx_cfg = cfg_q;

endmodule

`default_nettype wire

//--- src/mac_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mac_cmd_decoder (
    input  wire logic                                  tx_clk,
    input  wire logic                                  rst_n,
    input  wire logic                                  cmd_empty,
    input  wire mac_tx_bus_pkg::reg_cmd_t              cmd_data,
    output logic                                       cmd_ren,
    output mac_tx_bus_pkg::reg_write_t                 reg_write,
    input  wire logic [mac_tx_reg_pkg::REG_DATA_W-1:0] reg_rdata,
    output logic                                       read_req,
    output mac_tx_bus_pkg::reg_resp_t                  read_resp,
    input  wire logic                                  read_grant
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        WRITE = 2'd1,
        READ  = 2'd2
    } dec_state_e;

    dec_state_e state;
    dec_state_e state_nxt;
    logic       readable;
    logic       read_done;

    // only TDAR and TCR answer a read, the rest are write only
    assign readable = (cmd_data.addr == mac_tx_reg_pkg::TDAR) ||
                      (cmd_data.addr == mac_tx_reg_pkg::TCR);

    assign read_done = readable ? read_grant : 1'b1;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (!cmd_empty) begin
                    if (cmd_data.kind == mac_tx_bus_pkg::CMD_READ) begin
                        state_nxt = READ;
                    end else begin
                        state_nxt = WRITE;
                    end
                end
            end
            WRITE: begin
                state_nxt = IDLE;
            end
            READ: begin
                if (read_done) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // head stays in the queue until it is popped, so it feeds the write directly
    assign reg_write.en   = (state == WRITE);
    assign reg_write.addr = cmd_data.addr;
    assign reg_write.data = cmd_data.wdata;

    assign read_req       = (state == READ) && readable;
    assign read_resp.data = reg_rdata;
    assign read_resp.addr = cmd_data.addr;

    assign cmd_ren = (state == WRITE) || ((state == READ) && read_done);

    a_state_legal: assert property (
        @(posedge tx_clk) disable iff (!rst_n)
        state inside {IDLE, WRITE, READ}
    );

endmodule

`default_nettype wire

//--- src/mac_event_collector.sv
`timescale 1ns/1ps
`default_nettype none

module mac_event_collector (
    input  wire logic                                  tx_clk,
    input  wire logic                                  rst_n,
    input  wire mac_tx_bus_pkg::tx_event_t             tx_events,
    output logic                                       event_req,
    output logic [mac_tx_reg_pkg::REG_DATA_W-1:0]      event_word,
    input  wire logic                                  event_grant
);

    mac_tx_bus_pkg::tx_event_t pending;

    // pulses arriving in the grant cycle stay pending for the next report
    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else if (event_grant) begin
            pending <= tx_events;
        end else begin
            pending <= mac_tx_bus_pkg::tx_event_t'(pending | tx_events);
        end
    end

    assign event_req = |pending;

    always_comb begin
        event_word = '0;
        event_word[mac_tx_reg_pkg::EIR_BABT_BIT]  = pending.babt;
        event_word[mac_tx_reg_pkg::EIR_GRA_BIT]   = pending.gra;
        event_word[mac_tx_reg_pkg::EIR_TXF_BIT]   = pending.txf;
        event_word[mac_tx_reg_pkg::EIR_EBERR_BIT] = pending.eberr;
        event_word[mac_tx_reg_pkg::EIR_LC_BIT]    = pending.lc;
        event_word[mac_tx_reg_pkg::EIR_RL_BIT]    = pending.rl;
        event_word[mac_tx_reg_pkg::EIR_UN_BIT]    = pending.un;
    end

endmodule

`default_nettype wire

//--- src/mac_resp_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mac_resp_arbiter (
    input  wire logic                                  tx_clk,
    input  wire logic                                  rst_n,
    input  wire logic                                  event_req,
    input  wire logic [mac_tx_reg_pkg::REG_DATA_W-1:0] event_word,
    input  wire logic                                  read_req,
    input  wire mac_tx_bus_pkg::reg_resp_t             read_resp,
    input  wire logic                                  resp_full,
    output logic                                       event_grant,
    output logic                                       read_grant,
    output logic                                       resp_wen,
    output mac_tx_bus_pkg::reg_resp_t                  resp_data
);

    // fixed priority, event reports first
    assign event_grant = event_req && !resp_full;
    assign read_grant  = read_req && !event_req && !resp_full;
    assign resp_wen    = event_grant || read_grant;

    always_comb begin
        if (event_grant) begin
            resp_data.data = event_word;
            resp_data.addr = mac_tx_reg_pkg::EIR;
        end else begin
            resp_data = read_resp;
        end
    end

    a_no_write_when_full: assert property (
        @(posedge tx_clk) disable iff (!rst_n)
        resp_wen |-> !resp_full
    );

    a_one_grant: assert property (
        @(posedge tx_clk) disable iff (!rst_n)
        !(event_grant && read_grant)
    );

endmodule

`default_nettype wire

//--- src/mac_tx_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mac_tx_ctrl (
    input  wire logic                          tx_clk,
    input  wire logic                          rst_n,
    input  wire logic                          cmd_empty,
    output logic                               cmd_ren,
    input  wire mac_tx_bus_pkg::reg_cmd_t      cmd_data,
    input  wire logic                          resp_full,
    output logic                               resp_wen,
    output mac_tx_bus_pkg::reg_resp_t          resp_data,
    input  wire mac_tx_bus_pkg::tx_event_t     tx_events,
    output mac_tx_reg_pkg::tx_config_t         tx_cfg
);

    mac_tx_bus_pkg::reg_write_t             reg_write;
    logic [mac_tx_reg_pkg::REG_DATA_W-1:0]  reg_rdata;
    logic                                   read_req;
    mac_tx_bus_pkg::reg_resp_t              read_resp;
    logic                                   read_grant;
    logic                                   event_req;
    logic [mac_tx_reg_pkg::REG_DATA_W-1:0]  event_word;
    logic                                   event_grant;

    mac_cmd_decoder u_cmd_decoder (
        .tx_clk     (tx_clk),
        .rst_n      (rst_n),
        .cmd_empty  (cmd_empty),
        .cmd_data   (cmd_data),
        .cmd_ren    (cmd_ren),
        .reg_write  (reg_write),
        .reg_rdata  (reg_rdata),
        .read_req   (read_req),
        .read_resp  (read_resp),
        .read_grant (read_grant)
    );

    // read data follows the address at the head of the command queue
    mac_tx_regs u_regs (
        .tx_clk    (tx_clk),
        .rst_n     (rst_n),
        .reg_write (reg_write),
        .rd_addr   (cmd_data.addr),
        .rd_data   (reg_rdata),
        .txf_done  (tx_events.txf),
        .tx_cfg    (tx_cfg)
    );

    mac_event_collector u_event_collector (
        .tx_clk      (tx_clk),
        .rst_n       (rst_n),
        .tx_events   (tx_events),
        .event_req   (event_req),
        .event_word  (event_word),
        .event_grant (event_grant)
    );

    mac_resp_arbiter u_resp_arbiter (
        .tx_clk      (tx_clk),
        .rst_n       (rst_n),
        .event_req   (event_req),
        .event_word  (event_word),
        .read_req    (read_req),
        .read_resp   (read_resp),
        .resp_full   (resp_full),
        .event_grant (event_grant),
        .read_grant  (read_grant),
        .resp_wen    (resp_wen),
        .resp_data   (resp_data)
    );

endmodule

`default_nettype wire

//--- tests/tb_mac_tx_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mac_tx_ctrl;

    localparam int N_DIRECTED  = 32;
    localparam int N_RANDOM    = 40;
    localparam int CYCLE_LIMIT = 20 * (N_DIRECTED + N_RANDOM) + 200;

    typedef struct packed {
        mac_tx_reg_pkg::tx_config_t cfg;
        logic                       tdar;
    } model_t;

    logic                       tx_clk = 1'b0;
    logic                       rst_n = 1'b0;
    logic                       cmd_empty = 1'b1;
    logic                       cmd_ren;
    mac_tx_bus_pkg::reg_cmd_t   cmd_data = '0;
    logic                       resp_full = 1'b0;
    logic                       resp_wen;
    mac_tx_bus_pkg::reg_resp_t  resp_data;
    mac_tx_bus_pkg::tx_event_t  tx_events = '0;
    mac_tx_reg_pkg::tx_config_t tx_cfg;

    mac_tx_bus_pkg::reg_cmd_t   cmd_q[$];
    mac_tx_bus_pkg::reg_resp_t  exp_q[$];
    mac_tx_bus_pkg::reg_resp_t  exp_resp;
    model_t                     model = '0;
    logic [1:0]                 full_mode = 2'd0;
    int                         err_cnt = 0;
    int                         check_cnt = 0;
    int                         resp_cnt = 0;
    int                         test_err = 0;
    int                         cycle_cnt = 0;

    mac_tx_ctrl UUT (
        .tx_clk    (tx_clk),
        .rst_n     (rst_n),
        .cmd_empty (cmd_empty),
        .cmd_ren   (cmd_ren),
        .cmd_data  (cmd_data),
        .resp_full (resp_full),
        .resp_wen  (resp_wen),
        .resp_data (resp_data),
        .tx_events (tx_events),
        .tx_cfg    (tx_cfg)
    );

    always #5 tx_clk = ~tx_clk;

    // register contents after a write to the transmit register map
    function automatic model_t apply_write(model_t m, logic [11:0] addr, logic [31:0] data);
        case (addr)
            mac_tx_reg_pkg::ECR: begin
                m.cfg.ether_en = data[1];
                m.tdar         = m.tdar && data[1];
            end
            mac_tx_reg_pkg::TCR: begin
                m.cfg.gts       = data[0];
                m.cfg.fden      = data[2];
                m.cfg.tfc_pause = data[3];
                m.cfg.addins    = data[8];
                m.cfg.crcfwd    = data[9];
            end
            mac_tx_reg_pkg::TDAR: m.tdar = m.tdar || m.cfg.ether_en;
            mac_tx_reg_pkg::PALR: m.cfg.palr = data;
            mac_tx_reg_pkg::PAUR: m.cfg.paur = data;
            mac_tx_reg_pkg::OPD:  m.cfg.opd = data;
            mac_tx_reg_pkg::TDSR: m.cfg.tdsr = data;
            mac_tx_reg_pkg::TFWR: begin
                m.cfg.strfwd = data[8];
                m.cfg.tfwr   = data[7:0];
            end
            mac_tx_reg_pkg::TSEM: m.cfg.tsem = data[7:0];
            mac_tx_reg_pkg::TAEM: m.cfg.taem = data[7:0];
            mac_tx_reg_pkg::TAFL: m.cfg.tafl = data[7:0];
            mac_tx_reg_pkg::TIPG: m.cfg.tipg = data[15:0];
            default: ;
        endcase
        return m;
    endfunction

    function automatic logic [31:0] read_value(model_t m, logic [11:0] addr);
        logic [31:0] v;
        v = '0;
        if (addr == mac_tx_reg_pkg::TCR) begin
            v = {22'd0, m.cfg.crcfwd, m.cfg.addins, 4'd0, m.cfg.tfc_pause, m.cfg.fden,
                 1'b0, m.cfg.gts};
        end else if (addr == mac_tx_reg_pkg::TDAR) begin
            v[24] = m.tdar;
        end
        return v;
    endfunction

    // cause bits sit in EIR from babt at 29 down to un at 19
    function automatic logic [31:0] cause_word(mac_tx_bus_pkg::tx_event_t ev);
        return {2'b00, ev.babt, ev.gra, ev.txf, 4'd0, ev.eberr, ev.lc, ev.rl, ev.un, 19'd0};
    endfunction

    task automatic write_reg(logic [11:0] addr, logic [31:0] data);
        mac_tx_bus_pkg::reg_cmd_t c;
        c.kind  = mac_tx_bus_pkg::CMD_WRITE;
        c.addr  = addr;
        c.wdata = data;
        cmd_q.push_back(c);
        model = apply_write(model, addr, data);
    endtask

    task automatic read_reg(logic [11:0] addr);
        mac_tx_bus_pkg::reg_cmd_t  c;
        mac_tx_bus_pkg::reg_resp_t r;
        c.kind  = mac_tx_bus_pkg::CMD_READ;
        c.addr  = addr;
        c.wdata = $urandom();
        cmd_q.push_back(c);
        // write-only registers are popped without an answer
        if (addr == mac_tx_reg_pkg::TDAR || addr == mac_tx_reg_pkg::TCR) begin
            r.data = read_value(model, addr);
            r.addr = addr;
            exp_q.push_back(r);
        end
    endtask

    task automatic pulse_events(mac_tx_bus_pkg::tx_event_t ev);
        mac_tx_bus_pkg::reg_resp_t r;
        r.data = cause_word(ev);
        r.addr = mac_tx_reg_pkg::EIR;
        exp_q.push_back(r);
        if (ev.txf) begin
            model.tdar = 1'b0;
        end
        @(posedge tx_clk);
        tx_events <= ev;
        @(posedge tx_clk);
        tx_events <= '0;
    endtask

    task automatic drain();
        while (cmd_q.size() != 0 || !cmd_empty || exp_q.size() != 0) begin
            @(posedge tx_clk);
        end
        repeat (2) @(posedge tx_clk);
    endtask

    task automatic check_cfg();
        check_cnt = check_cnt + 1;
        if (tx_cfg !== model.cfg) begin
            $display("[ERROR] %0t tx_cfg expected %h got %h", $time, model.cfg, tx_cfg);
            err_cnt = err_cnt + 1;
        end
    endtask

    task automatic end_test(string name);
        $display("%s: %0d errors", name, err_cnt - test_err);
        test_err = err_cnt;
    endtask

    // behavioural command queue that shows its head while not empty
    always @(posedge tx_clk) begin
        if (cmd_ren) begin
            cmd_q.delete(0);
        end
        cmd_empty <= (cmd_q.size() == 0);
        if (cmd_q.size() != 0) begin
            cmd_data <= cmd_q[0];
        end
    end

    always @(posedge tx_clk) begin
        case (full_mode)
            2'd1: resp_full <= ($urandom % 3) == 0;
            2'd2: resp_full <= 1'b1;
            default: resp_full <= 1'b0;
        endcase
    end

    // response queue side
    always @(posedge tx_clk) begin
        if (rst_n && resp_wen) begin
            resp_cnt = resp_cnt + 1;
            if (resp_full) begin
                $display("response written at %0t while the queue was full", $time);
                err_cnt = err_cnt + 1;
            end
            if (exp_q.size() == 0) begin
                $display("unexpected response at %0t: %h", $time, resp_data);
                err_cnt = err_cnt + 1;
            end else begin
                exp_resp  = exp_q.pop_front();
                check_cnt = check_cnt + 1;
                if (resp_data !== exp_resp) begin
                    $display("[ERROR] %0t resp_data expected %h got %h", $time, exp_resp,
                             resp_data);
                    err_cnt = err_cnt + 1;
                end
            end
        end
    end

    always @(posedge tx_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, the DUT stalled", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(69195));
        repeat (3) @(posedge tx_clk);
        rst_n <= 1'b1;
        @(posedge tx_clk);
        check_cfg();
        repeat (10) @(posedge tx_clk);
        check_cnt = check_cnt + 1;
        if (resp_cnt != 0) begin
            $display("a response appeared with no command queued");
            err_cnt = err_cnt + 1;
        end
        end_test("reset state");

        write_reg(mac_tx_reg_pkg::PALR, $urandom());
        write_reg(mac_tx_reg_pkg::PAUR, $urandom());
        write_reg(mac_tx_reg_pkg::OPD, $urandom());
        write_reg(mac_tx_reg_pkg::TDSR, $urandom());
        write_reg(mac_tx_reg_pkg::TFWR, 32'h0000_0135);
        write_reg(mac_tx_reg_pkg::TSEM, $urandom());
        write_reg(mac_tx_reg_pkg::TAEM, $urandom());
        write_reg(mac_tx_reg_pkg::TAFL, $urandom());
        write_reg(mac_tx_reg_pkg::TIPG, $urandom());
        drain();
        check_cfg();
        end_test("config registers");

        write_reg(mac_tx_reg_pkg::ECR, 32'h0000_0002);
        write_reg(mac_tx_reg_pkg::TCR, 32'hFFFF_FFFF);
        read_reg(mac_tx_reg_pkg::TCR);
        read_reg(mac_tx_reg_pkg::PALR);
        read_reg(mac_tx_reg_pkg::TSEM);
        write_reg(mac_tx_reg_pkg::TCR, 32'h0000_0104);
        read_reg(mac_tx_reg_pkg::TCR);
        drain();
        check_cfg();
        end_test("tcr readback");

        write_reg(mac_tx_reg_pkg::TDAR, 32'h0100_0000);
        read_reg(mac_tx_reg_pkg::TDAR);
        drain();
        pulse_events(7'b0010000);
        drain();
        read_reg(mac_tx_reg_pkg::TDAR);
        write_reg(mac_tx_reg_pkg::TDAR, 32'h0100_0000);
        read_reg(mac_tx_reg_pkg::TDAR);
        write_reg(mac_tx_reg_pkg::ECR, 32'h0000_0000);
        read_reg(mac_tx_reg_pkg::TDAR);
        write_reg(mac_tx_reg_pkg::ECR, 32'h0000_0002);
        drain();
        end_test("tdar set and clear");

        // event report and TCR read both wait behind a full queue
        full_mode <= 2'd2;
        repeat (2) @(posedge tx_clk);
        pulse_events(7'b1001011);
        read_reg(mac_tx_reg_pkg::TCR);
        repeat (8) @(posedge tx_clk);
        full_mode <= 2'd0;
        drain();
        pulse_events(7'h7F);
        drain();
        end_test("event reports");

        full_mode <= 2'd1;
        for (int i = 0; i < N_RANDOM; i++) begin
            case ($urandom % 6)
                0: write_reg(mac_tx_reg_pkg::TCR, $urandom());
                1: read_reg(mac_tx_reg_pkg::TCR);
                2: write_reg(mac_tx_reg_pkg::TDAR, 32'h0100_0000);
                3: read_reg(mac_tx_reg_pkg::TDAR);
                4: read_reg(mac_tx_reg_pkg::OPD);
                default: write_reg(mac_tx_reg_pkg::ECR, ($urandom % 4 != 0) ? 32'h2 : 32'h0);
            endcase
            @(posedge tx_clk);
        end
        drain();
        pulse_events(7'b0100100);
        drain();
        check_cfg();
        full_mode <= 2'd0;
        end_test("random back-pressure");

        $display("checks %0d, responses %0d, errors %0d", check_cnt, resp_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
